//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/100ps
TOP       = tb_uart_monitor
FILE_LIST = uart_monitor.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Test FAILED
PASS_MSG  = Test OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/byte_ram.sv
`timescale 1ns/100ps
`default_nettype none

module byte_ram import uart_mon_pkg::*; (
    input  logic    clk,
    mem_port_if.mem mem
);

    byte_t mem_array [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem.we) begin
            mem_array[mem.addr] <= mem.wdata;
        end
    end

    // Combinational read port
    assign mem.rdata = mem_array[mem.addr];

endmodule

`default_nettype wire

//--- hdl/cmd_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_decoder import uart_mon_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  byte_t    rx_data,
    input  logic     rx_done,
    mem_port_if.ctrl mem,
    tx_byte_if.src   tx
);

    dec_state_t state_q;
    dec_state_t state_d;
    byte_t      cmd_q;
    byte_t      addr_q;
    byte_t      data_q;
    byte_t      reply_q;
    logic       is_read;
    logic       is_write;
    logic       is_ping;

    assign is_read  = (cmd_q == CMD_READ);
    assign is_write = (cmd_q == CMD_WRITE);
    assign is_ping  = (cmd_q == CMD_PING);

    // Upper address bits are dropped, so addresses wrap
    assign mem.addr  = addr_q[ADDR_BITS-1:0];
    assign mem.wdata = data_q;
    assign mem.we    = (state_q == EXEC) && is_write;

    assign tx.data  = reply_q;
    assign tx.start = (state_q == SEND_RESP);

    always_comb begin
        state_d = state_q;
        case (state_q)
            WAIT_CMD: begin
                if (rx_done) state_d = WAIT_ADDR;
            end
            WAIT_ADDR: begin
                if (rx_done) state_d = WAIT_DATA;
            end
            WAIT_DATA: begin
                if (rx_done) state_d = EXEC;
            end
            // Unknown commands and writes send nothing back
            EXEC: begin
                state_d = (is_read || is_ping) ? SEND_RESP : WAIT_CMD;
            end
            SEND_RESP: begin
                if (!tx.busy) state_d = SEND_WAIT;
            end
            SEND_WAIT: begin
                if (tx.done) state_d = WAIT_CMD;
            end
            default: state_d = WAIT_CMD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= WAIT_CMD;
        end else begin
            state_q <= state_d;
        end
    end

    // Frame bytes and reply
    always_ff @(posedge clk) begin
        if (rx_done) begin
            case (state_q)
                WAIT_CMD:  cmd_q  <= rx_data;
                WAIT_ADDR: addr_q <= rx_data;
                WAIT_DATA: data_q <= rx_data;
                default:   ;
            endcase
        end
        if (state_q == EXEC) begin
            reply_q <= is_read ? mem.rdata : PING_REPLY;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mem_port_if.sv
`timescale 1ns/100ps
`default_nettype none

interface mem_port_if import uart_mon_pkg::*; ();

    logic [ADDR_BITS-1:0] addr;
    byte_t                wdata;
    logic                 we;
    // Follows addr in the same cycle
    byte_t                rdata;

    modport ctrl (output addr, output wdata, output we, input rdata);
    modport mem  (input addr, input wdata, input we, output rdata);

endinterface

`default_nettype wire

//--- hdl/tx_byte_if.sv
`timescale 1ns/100ps
`default_nettype none

interface tx_byte_if import uart_mon_pkg::*; ();

    byte_t data;
    // One-cycle request, only while busy is low
    logic  start;
    logic  busy;
    logic  done;

    modport src  (output data, output start, input busy, input done);
    modport sink (input data, input start, output busy, output done);

endinterface

`default_nettype wire

//--- hdl/uart_mon_pkg.sv
`default_nettype none

package uart_mon_pkg;

    localparam int DATA_BITS = 8;
    localparam int CLK_BITS  = 10;
    localparam int MEM_DEPTH = 64;
    localparam int ADDR_BITS = 6;

    typedef logic [DATA_BITS-1:0] byte_t;

    // Monitor command codes
    typedef enum logic [7:0] {
        CMD_READ  = 8'hA3,
        CMD_WRITE = 8'h5C,
        CMD_PING  = 8'hF0
    } cmd_t;

    localparam byte_t PING_REPLY = 8'hAA;

    // Frame collection and reply states
    typedef enum logic [2:0] {
        WAIT_CMD,
        WAIT_ADDR,
        WAIT_DATA,
        EXEC,
        SEND_RESP,
        SEND_WAIT
    } dec_state_t;

endpackage

`default_nettype wire

//--- hdl/uart_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module uart_monitor import uart_mon_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [CLK_BITS-1:0] clk_per_bit,
    input  logic                uart_rx,
    output logic                uart_tx
);

    byte_t rx_data;
    logic  rx_done;

    mem_port_if mem_bus ();
    tx_byte_if  tx_bus ();

    uart_rx rx_i (
        .clk         (clk),
        .rst         (rst),
        .clk_per_bit (clk_per_bit),
        .rx_line     (uart_rx),
        .rx_data     (rx_data),
        .rx_done     (rx_done)
    );

    cmd_decoder dec_i (
        .clk     (clk),
        .rst     (rst),
        .rx_data (rx_data),
        .rx_done (rx_done),
        .mem     (mem_bus.ctrl),
        .tx      (tx_bus.src)
    );

    byte_ram ram_i (
        .clk (clk),
        .mem (mem_bus.mem)
    );

    uart_tx tx_i (
        .clk         (clk),
        .rst         (rst),
        .clk_per_bit (clk_per_bit),
        .tx          (tx_bus.sink),
        .tx_line     (uart_tx)
    );

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx import uart_mon_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [CLK_BITS-1:0] clk_per_bit,
    input  logic                rx_line,
    output byte_t               rx_data,
    output logic                rx_done
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t           state;
    logic                line_meta;
    logic                line_sync;
    logic [CLK_BITS-1:0] cyc_cnt;
    logic [2:0]          bit_cnt;
    byte_t               shift_reg;
    logic                bit_end;
    logic                half_end;

    assign bit_end  = (cyc_cnt == clk_per_bit - 1'b1);
    assign half_end = (cyc_cnt == (clk_per_bit >> 1) - 1'b1);

    // Two-stage synchronizer that idles high like the line
    always_ff @(posedge clk) begin
        if (rst) begin
            line_meta <= 1'b1;
            line_sync <= 1'b1;
        end else begin
            line_meta <= rx_line;
            line_sync <= line_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            cyc_cnt <= '0;
            bit_cnt <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cyc_cnt <= '0;
                    bit_cnt <= '0;
                    if (!line_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (half_end) begin
                        cyc_cnt <= '0;
                        // Glitch shorter than half a bit goes back to idle
                        state   <= line_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cyc_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'(DATA_BITS - 1)) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        cyc_cnt <= '0;
                        state   <= RX_IDLE;
                        rx_done <= line_sync;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) begin
            shift_reg <= {line_sync, shift_reg[DATA_BITS-1:1]};
        end
        if (state == RX_STOP && bit_end && line_sync) begin
            rx_data <= shift_reg;
        end
    end

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx import uart_mon_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [CLK_BITS-1:0] clk_per_bit,
    tx_byte_if.sink             tx,
    output logic                tx_line
);

    localparam int FRAME_BITS = DATA_BITS + 2;

    logic [FRAME_BITS-1:0] frame;
    logic [CLK_BITS-1:0]   cyc_cnt;
    logic [3:0]            bit_cnt;
    logic                  bit_end;

    assign bit_end = (cyc_cnt == clk_per_bit - 1'b1);

    // Bit 0 of the frame register is the line itself
    assign tx_line = frame[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            frame   <= '1;
            cyc_cnt <= '0;
            bit_cnt <= '0;
            tx.busy <= 1'b0;
            tx.done <= 1'b0;
        end else begin
            tx.done <= 1'b0;
            if (!tx.busy) begin
                cyc_cnt <= '0;
                bit_cnt <= '0;
                if (tx.start) begin
                    // Stop, payload, start from MSB down
                    frame   <= {1'b1, tx.data, 1'b0};
                    tx.busy <= 1'b1;
                end
            end else if (bit_end) begin
                cyc_cnt <= '0;
                frame   <= {1'b1, frame[FRAME_BITS-1:1]};
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                    tx.busy <= 1'b0;
                    tx.done <= 1'b1;
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 8;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset held for eight rising edges and released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/tb_uart_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uart_monitor import uart_mon_pkg::*; ();

    localparam int BIT_CYCLES    = 8;
    localparam int STIM_FRAMES   = 32;
    localparam int STIM_COLS     = 5;
    localparam int RESET_TIMEOUT = 100;
    localparam int REPLY_TIMEOUT = 60 * BIT_CYCLES;
    localparam int QUIET_CYCLES  = 40 * BIT_CYCLES;
    localparam int SEED          = 52416;

    logic                clk;
    logic                rst;
    logic [CLK_BITS-1:0] clk_per_bit;
    logic                uart_rx;
    logic                uart_tx;
    // Ninth bit marks words the stim file did not fill
    logic [8:0]          stim_words [STIM_FRAMES*STIM_COLS];
    int                  error_count;

    clock_gen clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    uart_monitor uart_monitor_i (
        .clk         (clk),
        .rst         (rst),
        .clk_per_bit (clk_per_bit),
        .uart_rx     (uart_rx),
        .uart_tx     (uart_tx)
    );

    bind cmd_decoder uart_monitor_asserts asserts_i (
        .clk   (clk),
        .rst   (rst),
        .start (tx.start),
        .busy  (tx.busy),
        .we    (mem.we)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input byte_t actual, input byte_t expected);
        if (actual !== expected) begin
            error_count++;
            abort_run($sformatf("MISMATCH at %0t ns: %s got 0x%02h, expected 0x%02h",
                $time, name, actual, expected));
        end
    endtask

    // Idle line for 1 to 3 bit times
    task automatic idle_gap();
        int gap_bits;
        gap_bits = 1 + int'($urandom % 3);
        uart_rx <= 1'b1;
        repeat (gap_bits * BIT_CYCLES) @(negedge clk);
    endtask

    // Last byte of a frame leaves the stop bit running so the reply can be watched
    task automatic send_byte(input byte_t value, input bit last);
        uart_rx <= 1'b0;
        repeat (BIT_CYCLES) @(negedge clk);
        for (int i = 0; i < DATA_BITS; i++) begin
            uart_rx <= value[i];
            repeat (BIT_CYCLES) @(negedge clk);
        end
        uart_rx <= 1'b1;
        if (!last) begin
            repeat (BIT_CYCLES) @(negedge clk);
            idle_gap();
        end
    endtask

    task automatic receive_reply(input byte_t expected);
        byte_t value;
        bit    seen;
        seen = 1'b0;
        for (int n = 0; n < REPLY_TIMEOUT && !seen; n++) begin
            @(negedge clk);
            seen = !uart_tx;
        end
        if (!seen) begin
            abort_run("Timeout: no reply start bit appeared on uart_tx");
        end
        // Step from half a cycle into the start bit to its middle
        repeat (BIT_CYCLES / 2) @(negedge clk);
        check_value("uart_tx start bit", byte_t'(uart_tx), 8'h00);
        for (int i = 0; i < DATA_BITS; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            value[i] = uart_tx;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        check_value("uart_tx stop bit", byte_t'(uart_tx), 8'h01);
        check_value("uart_tx reply", value, expected);
    endtask

    task automatic expect_quiet();
        for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk);
            if (!uart_tx) begin
                abort_run($sformatf("Unexpected start bit on uart_tx at %0t ns", $time));
            end
        end
    endtask

    initial begin
        int frame_count;
        int base;
        bit reset_done;
        uart_rx     = 1'b1;
        clk_per_bit = CLK_BITS'(BIT_CYCLES);
        error_count = 0;
        void'($urandom(SEED));
        for (int i = 0; i < STIM_FRAMES * STIM_COLS; i++) begin
            stim_words[i] = '1;
        end
        $readmemh("testbench/uart_monitor_stim.txt", stim_words);
        frame_count = 0;
        while (frame_count < STIM_FRAMES && stim_words[frame_count * STIM_COLS] != 9'h1FF) begin
            frame_count++;
        end
        if (frame_count == 0) begin
            abort_run("No command frames found in the stim file");
        end
        reset_done = 1'b0;
        for (int n = 0; n < RESET_TIMEOUT && !reset_done; n++) begin
            @(negedge clk);
            reset_done = !rst;
        end
        if (!reset_done) begin
            abort_run("Timeout: reset was never released");
        end
        idle_gap();
        for (int f = 0; f < frame_count; f++) begin
            base = f * STIM_COLS;
            send_byte(stim_words[base][7:0], 1'b0);
            send_byte(stim_words[base + 1][7:0], 1'b0);
            send_byte(stim_words[base + 2][7:0], 1'b1);
            if (stim_words[base + 3][0]) begin
                receive_reply(stim_words[base + 4][7:0]);
            end else begin
                expect_quiet();
            end
            idle_gap();
        end
        if (error_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

//--- testbench/uart_monitor_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module uart_monitor_asserts (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic we
);

    // Reply request only toward an idle transmitter
    start_while_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(start) |-> !busy)
        else $error("reply start raised while the transmitter is busy");

    // Transmitter takes the request on the next edge
    busy_after_start: assert property (@(posedge clk) disable iff (rst)
        start |=> busy)
        else $error("transmitter did not go busy after start");

    write_and_start: assert property (@(posedge clk) disable iff (rst)
        !(we && start))
        else $error("memory write and reply start in the same cycle");

    // EXEC lasts one cycle
    write_one_cycle: assert property (@(posedge clk) disable iff (rst)
        we |=> !we)
        else $error("memory write enable high for two cycles in a row");

endmodule

`default_nettype wire

//--- testbench/uart_monitor_stim.txt
// Columns: command, address, data, reply expected (1/0), expected reply byte
// All values in hex, one frame per line
F0 00 00 1 AA
F0 3F 5A 1 AA
5C 00 11 0 00
A3 00 00 1 11
5C 3F C3 0 00
A3 3F 00 1 C3
5C 15 7E 0 00
A3 15 00 1 7E
A3 55 00 1 7E
A3 7F 00 1 C3
5C 15 E1 0 00
A3 15 00 1 E1
5C 80 2D 0 00
A3 00 00 1 2D
12 00 00 0 00
F0 21 00 1 AA

//--- uart_monitor.f
hdl/uart_mon_pkg.sv
hdl/mem_port_if.sv
hdl/tx_byte_if.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/cmd_decoder.sv
hdl/byte_ram.sv
hdl/uart_monitor.sv
testbench/clock_gen.sv
testbench/uart_monitor_asserts.sv
testbench/tb_uart_monitor.sv
